/* logic/wrr_pkg.sv */
// sizes and types shared by the arbiter and its testbench
// three requesters only; the picker's modulo scan assumes N_REQ stays small
package wrr_pkg;

   localparam int N_REQ = 3;
   localparam int WT_W  = 4;
   localparam int POS_W = $clog2(N_REQ);

   // one bit per requester: requests, grants, eligibility, picks
   typedef logic [N_REQ-1:0] req_vec_t;

   // weight or live credit count
   typedef logic [WT_W-1:0] weight_t;

   // element i belongs to requester i
   typedef weight_t [N_REQ-1:0] weight_vec_t;

   // requester index
   typedef logic [POS_W-1:0] pos_t;

   typedef enum logic [1:0]
   {
      IDLE = 2'd0,   // no weights loaded yet
      ARM  = 2'd1,   // no grant outstanding
      BUSY = 2'd2    // one requester owns the bus
   } arb_state_e;

endpackage

/* logic/arb_if.sv */
// internal arbiter interface, single clock domain
// eligible, pick and pick_valid are combinational within one cycle
`timescale 1ns/1ns

interface arb_if;
   import wrr_pkg::*;

   req_vec_t eligible;     // req masked by nonzero credit
   req_vec_t pick;         // one-hot or zero
   logic     pick_valid;
   logic     take;         // commit pick on this edge
   logic     load;         // capture new weights
   logic     reload;       // credits back to stored weights

   modport fsm (
      input  pick,
      input  pick_valid,
      output take,
      output load,
      output reload
   );

   modport credits (
      input  pick,
      input  take,
      input  load,
      input  reload,
      output eligible
   );

   modport picker (
      input  eligible,
      input  take,
      output pick,
      output pick_valid
   );

endinterface

/* logic/reset_sync.sv */
// asserts with resetb, releases on the second rising clk after resetb goes high
`timescale 1ns/1ns

module reset_sync (
   input  logic clk,
   input  logic resetb,
   output logic rst_n
);

   logic rst_meta;

   always_ff @(posedge clk or negedge resetb)
   begin
      if (!resetb)
      begin
         rst_meta <= 1'b0;
         rst_n    <= 1'b0;
      end
      else
      begin
         rst_meta <= 1'b1;
         rst_n    <= rst_meta;
      end
   end

endmodule

/* logic/rr_picker.sv */
// rotating priority, search starts one past the last committed position
// pick is combinational from eligible; position moves only on take
`timescale 1ns/1ns

module rr_picker (
   input  logic clk,
   input  logic rst_n,
   arb_if.picker bus
);
   import wrr_pkg::*;

   pos_t     last_pos;
   pos_t     pick_pos;
   req_vec_t pick;

   // scan from farthest to nearest so the nearest eligible wins
   always_comb
   begin
      int cand;
      pick     = '0;
      pick_pos = last_pos;
      cand     = 0;
      for (int k = N_REQ; k >= 1; k--)
      begin
         cand = (int'(last_pos) + k) % N_REQ;
         if (bus.eligible[cand])
         begin
            pick       = '0;
            pick[cand] = 1'b1;
            pick_pos   = pos_t'(cand);
         end
      end
   end

   assign bus.pick       = pick;
   assign bus.pick_valid = |bus.eligible;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         last_pos <= pos_t'(N_REQ - 1);   // first search starts at 0
      else if (bus.take)
         last_pos <= pick_pos;
   end

   a_pick_onehot : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(bus.pick)
   ) else $error("picker selected more than one requester");

   // eligible comes from the credit counters
   a_pick_in_eligible : assert property (
      @(posedge clk) disable iff (!rst_n)
      (bus.pick & ~bus.eligible) == '0
   ) else $error("pick outside the eligible set");

   // take is issued by the FSM and needs a valid pick behind it
   a_take_has_pick : assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.take |-> bus.pick_valid
   ) else $error("take without a valid pick");

endmodule

/* logic/credit_counters.sv */
// load wins over reload, reload over take; a zero weight blocks that requester
// stored weights are only meaningful after the first load
`timescale 1ns/1ns

module credit_counters (
   input  logic                 clk,
   input  logic                 rst_n,
   input  wrr_pkg::req_vec_t    req,
   input  wrr_pkg::weight_vec_t weights,
   arb_if.credits               bus
);
   import wrr_pkg::*;

   weight_vec_t stored;
   weight_vec_t credit;
   req_vec_t    has_credit;

   always_ff @(posedge clk)
   begin
      if (bus.load)
         stored <= weights;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         credit <= '0;
      else if (bus.load)
         credit <= weights;
      else if (bus.reload)
         credit <= stored;
      else if (bus.take)
      begin
         for (int i = 0; i < N_REQ; i++)
         begin
            if (bus.pick[i])
               credit[i] <= credit[i] - 1'b1;
         end
      end
   end

   always_comb
   begin
      for (int i = 0; i < N_REQ; i++)
      begin
         has_credit[i] = (credit[i] != '0);
      end
   end

   assign bus.eligible = req & has_credit;

   // pick and take come from the picker and FSM
   a_no_underflow : assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.take |-> ((bus.pick & ~has_credit) == '0)
   ) else $error("credit decremented from zero");

endmodule

/* logic/arb_fsm.sv */
// gnt is registered and holds until the owner pulses its end_access bit
// wt_load is accepted only in IDLE and ARM
`timescale 1ns/1ns

module arb_fsm (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wt_load,
   input  wrr_pkg::req_vec_t end_access,
   output wrr_pkg::req_vec_t gnt,
   arb_if.fsm                bus
);
   import wrr_pkg::*;

   arb_state_e state;
   arb_state_e next_state;
   req_vec_t   next_gnt;
   logic       access_done;
   logic       take;
   logic       load;
   logic       reload;

   // only the current owner can end its access
   assign access_done = |(end_access & gnt);

   always_comb
   begin
      next_state = state;
      next_gnt   = gnt;
      take       = 1'b0;
      load       = 1'b0;
      reload     = 1'b0;

      case (state)
         IDLE:
         begin
            next_gnt = '0;
            if (wt_load)
            begin
               load       = 1'b1;
               next_state = ARM;
            end
         end
         ARM:
         begin
            if (wt_load)
               load = 1'b1;   // new weights, arbitrate next cycle
            else if (bus.pick_valid)
            begin
               take       = 1'b1;
               next_gnt   = bus.pick;
               next_state = BUSY;
            end
            else
               reload = 1'b1;
         end
         BUSY:
         begin
            if (access_done)
            begin
               if (bus.pick_valid)
               begin
                  take     = 1'b1;
                  next_gnt = bus.pick;
               end
               else
               begin
                  next_gnt   = '0;
                  reload     = 1'b1;
                  next_state = ARM;
               end
            end
         end
         default:
         begin
            next_gnt   = '0;
            next_state = IDLE;
         end
      endcase
   end

   assign bus.take   = take;
   assign bus.load   = load;
   assign bus.reload = reload;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= IDLE;
         gnt   <= '0;
      end
      else
      begin
         state <= next_state;
         gnt   <= next_gnt;
      end
   end

   a_gnt_onehot : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(gnt)
   ) else $error("more than one grant");

   a_gnt_only_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state != BUSY) |-> (gnt == '0)
   ) else $error("grant outside BUSY");

endmodule

/* logic/wrr_arbiter.sv */
// weights take effect only through wt_load in IDLE or ARM
// gnt stays zero until the second rising clk after resetb is released
`timescale 1ns/1ns

module wrr_arbiter (
   input  logic              clk,
   input  logic              resetb,
   input  wrr_pkg::req_vec_t req,
   input  wrr_pkg::req_vec_t end_access,
   input  logic              wt_load,
   input  wrr_pkg::weight_t  wt_0,
   input  wrr_pkg::weight_t  wt_1,
   input  wrr_pkg::weight_t  wt_2,
   output wrr_pkg::req_vec_t gnt
);
   import wrr_pkg::*;

   logic        rst_n;
   weight_vec_t weights;

   assign weights = {wt_2, wt_1, wt_0};   // element i for requester i

   arb_if bus ();

   reset_sync u_reset_sync (
      .clk    (clk),
      .resetb (resetb),
      .rst_n  (rst_n)
   );

   credit_counters u_credits (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .weights (weights),
      .bus     (bus.credits)
   );

   rr_picker u_picker (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (bus.picker)
   );

   arb_fsm u_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .wt_load    (wt_load),
      .end_access (end_access),
      .gnt        (gnt),
      .bus        (bus.fsm)
   );

endmodule

/* test/tb_clock_gen.sv */
// 40 ns clock; resetb held low over the first two rising edges
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic resetb
);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      resetb = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;   // release on a falling edge
   end

endmodule

/* test/wrr_model.svh */
// cycle model of the arbiter, include inside a module that imports wrr_pkg
// step it once per rising clk with the inputs present at that edge
`ifndef WRR_MODEL_SVH
`define WRR_MODEL_SVH

arb_state_e m_state;
req_vec_t   m_gnt;
pos_t       m_last;
weight_t    m_credit [N_REQ];
weight_t    m_stored [N_REQ];
logic [1:0] m_sync;   // core held until both bits are set

task automatic model_reset();
   m_state = IDLE;
   m_gnt   = '0;
   m_last  = pos_t'(N_REQ - 1);
   m_sync  = 2'b00;
   for (int i = 0; i < N_REQ; i++)
   begin
      m_credit[i] = '0;
      m_stored[i] = '0;
   end
endtask

// first position after the last grant with request and credit, -1 if none
function automatic int model_pick(input req_vec_t rq);
   int pos;
   int cand;
   pos = -1;
   for (int k = 1; k <= N_REQ; k++)
   begin
      cand = (int'(m_last) + k) % N_REQ;
      if (pos < 0 && rq[cand] && m_credit[cand] != '0)
         pos = cand;
   end
   return pos;
endfunction

task automatic model_step(input logic rb, input req_vec_t rq, input req_vec_t ea,
                          input logic ld, input weight_vec_t w);
   int   sel;
   logic load;
   logic take;
   logic reload;
   if (!rb)
      model_reset();
   else if (!m_sync[1])
      m_sync = {m_sync[0], 1'b1};
   else
   begin
      sel    = model_pick(rq);
      load   = ld && (m_state != BUSY);
      take   = 1'b0;
      reload = 1'b0;
      case (m_state)
         IDLE: if (ld) m_state = ARM;
         ARM:
         begin
            take   = !ld && sel >= 0;
            reload = !ld && sel < 0;
         end
         default:
         begin
            if ((ea & m_gnt) != '0)
            begin
               take   = sel >= 0;
               reload = sel < 0;
            end
         end
      endcase
      if (take)
      begin
         m_gnt   = req_vec_t'(1 << sel);
         m_last  = pos_t'(sel);
         m_state = BUSY;
      end
      else if (reload)
      begin
         m_gnt   = '0;
         m_state = ARM;
      end
      for (int i = 0; i < N_REQ; i++)
      begin
         if (load)
         begin
            m_credit[i] = w[i];
            m_stored[i] = w[i];
         end
         else if (reload)
            m_credit[i] = m_stored[i];
         else if (take && i == sel)
            m_credit[i] = m_credit[i] - 1'b1;
      end
   end
endtask

`endif

/* test/tb_wrr_arbiter.sv */
// requesters are emulated here and checked each cycle against the cycle model
// random stimulus from seed 52912; every wait gives up after WAIT_LIMIT cycles
`timescale 1ns/1ns

module tb_wrr_arbiter;
   import wrr_pkg::*;

   `include "wrr_model.svh"

   localparam int WAIT_LIMIT = 300;
   localparam int REQ_OFF    = 0;
   localparam int REQ_ALL    = 1;
   localparam int REQ_RAND   = 2;

   logic        clk;
   logic        resetb;
   req_vec_t    req;
   req_vec_t    end_access;
   logic        wt_load;
   weight_vec_t wts;
   req_vec_t    gnt;
   int          req_mode;
   int          len_min;
   int          len_max;
   int          hold [N_REQ];   // cycles left in an access, -1 when idle
   req_vec_t    prev_gnt;
   req_vec_t    prev_end;
   int          errors;
   int          mark;
   int          tests;

   tb_clock_gen u_clk_gen (
      .clk    (clk),
      .resetb (resetb)
   );

   wrr_arbiter u_dut (
      .clk        (clk),
      .resetb     (resetb),
      .req        (req),
      .end_access (end_access),
      .wt_load    (wt_load),
      .wt_0       (wts[0]),
      .wt_1       (wts[1]),
      .wt_2       (wts[2]),
      .gnt        (gnt)
   );

   always @(posedge clk)
      model_step(resetb, req, end_access, wt_load, wts);

   task automatic check_gnt(input string what, input req_vec_t got, input req_vec_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t ns", what, got, exp, $time);
         errors++;
      end
   endtask

   task automatic check_state_idle(input arb_state_e got);
      if (got !== IDLE)
      begin
         $display("Mismatch state: got 0x%0h, expected 0x%0h at %0t ns", got, IDLE, $time);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input weight_t got, input weight_t exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t ns", what, got, exp, $time);
         errors++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR: %s at %0t ns", msg, $time);
      errors++;
   endtask

   task automatic abort_run(input string why);
      $display("ERROR: %s at %0t ns, %0d earlier errors", why, $time, errors);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors == mark)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - mark);
      mark = errors;
   endtask

   task automatic drive_requesters();
      for (int i = 0; i < N_REQ; i++)
      begin
         end_access[i] = 1'b0;
         if (gnt[i])
         begin
            if (hold[i] < 0)   // new access
               hold[i] = len_min - 1 + int'($urandom % (len_max - len_min + 1));
            if (hold[i] == 0)
            begin
               end_access[i] = 1'b1;
               hold[i]       = -1;
               req[i] = (req_mode == REQ_ALL) || (req_mode == REQ_RAND && $urandom % 2 == 1);
            end
            else
               hold[i]--;
         end
         else if (req_mode == REQ_OFF)
            req[i] = 1'b0;
         else if (req_mode == REQ_ALL || $urandom % 4 == 0)
            req[i] = 1'b1;   // stays up until granted
      end
   endtask

   // one falling edge: compare, then drive the next inputs
   task automatic next_cycle();
      @(negedge clk);
      check_gnt("gnt", gnt, m_gnt);
      if (prev_gnt != '0 && gnt != prev_gnt && (prev_end & prev_gnt) == '0)
         report_error("grant changed while its owner still held the access");
      for (int i = 0; i < N_REQ; i++)
      begin
         if (gnt[i] && m_stored[i] == '0)
            report_error($sformatf("requester %0d granted with weight 0", i));
      end
      prev_gnt = gnt;
      drive_requesters();
      prev_end = end_access;
      wt_load  = 1'b0;
   endtask

   task automatic load_weights(input weight_vec_t w);
      next_cycle();
      wt_load = 1'b1;
      wts     = w;
   endtask

   task automatic wait_grant();
      int n;
      n = 0;
      while (gnt == '0)
      begin
         if (n == WAIT_LIMIT)
            abort_run("no grant arrived");
         next_cycle();
         n++;
      end
   endtask

   task automatic wait_bus_free();
      int n;
      n = 0;
      req_mode = REQ_OFF;
      while (gnt != '0)
      begin
         if (n == WAIT_LIMIT)
            abort_run("bus was never released");
         next_cycle();
         n++;
      end
      next_cycle();
   endtask

   function automatic weight_vec_t random_weights();
      weight_vec_t w;
      w = {weight_t'($urandom), weight_t'($urandom), weight_t'($urandom)};
      if ($urandom % 2 == 0)
         w[$urandom % N_REQ] = '0;   // blocked requester
      return w;
   endfunction

   task automatic test_reset();
      req_mode = REQ_ALL;
      for (int c = 0; c < 10; c++)
      begin
         next_cycle();
         check_gnt("gnt", gnt, '0);
         check_state_idle(m_state);
      end
      finish_test("reset");
   endtask

   task automatic test_round_robin();
      req_vec_t expected [4];
      expected = '{3'b001, 3'b010, 3'b100, 3'b001};
      req_mode = REQ_ALL;
      len_min  = 1;
      len_max  = 1;
      load_weights({4'd1, 4'd1, 4'd1});
      next_cycle();
      check_gnt("gnt", gnt, '0);   // ARM cycle
      next_cycle();
      for (int k = 0; k < 4; k++)
      begin
         if (k > 0)
         begin
            next_cycle();
            wait_grant();
         end
         check_gnt("gnt", gnt, expected[k]);
      end
      finish_test("round robin");
   endtask

   task automatic test_weighted();
      weight_t expected [N_REQ];
      weight_t cnt [N_REQ];
      int      n;
      expected = '{4'd3, 4'd1, 4'd2};
      wait_bus_free();
      req_mode = REQ_ALL;
      len_min  = 1;
      len_max  = 1;
      load_weights({expected[2], expected[1], expected[0]});
      wait_grant();
      for (int p = 0; p < 3; p++)
      begin
         n = 0;
         for (int i = 0; i < N_REQ; i++)
            cnt[i] = '0;
         while (gnt != '0)
         begin
            for (int i = 0; i < N_REQ; i++)
               cnt[i] = cnt[i] + weight_t'(gnt[i]);
            if (n == WAIT_LIMIT)
               abort_run("reload period never ended");
            next_cycle();
            n++;
         end
         for (int i = 0; i < N_REQ; i++)
            check_count($sformatf("grant count %0d", i), cnt[i], expected[i]);
         next_cycle();   // credits reloaded in the zero cycle
         if (gnt == '0)
            report_error("no grant in the cycle after the credit reload");
      end
      finish_test("weighted sharing");
   endtask

   task automatic test_back_pressure();
      wait_bus_free();
      req_mode = REQ_ALL;
      len_min  = 3;
      len_max  = 6;
      load_weights({4'd2, 4'd2, 4'd2});
      for (int c = 0; c < 150; c++)
         next_cycle();
      finish_test("hold under back-pressure");
   endtask

   task automatic test_random();
      wait_bus_free();
      req_mode = REQ_RAND;
      len_min  = 1;
      len_max  = 5;
      load_weights(random_weights());
      for (int c = 0; c < 3000; c++)
      begin
         next_cycle();
         if (m_state == ARM && $urandom % 20 == 0)
         begin
            wt_load = 1'b1;
            wts     = random_weights();
         end
      end
      finish_test("random long run");
   endtask

   initial
   begin
      void'($urandom(52912));
      req        = '0;
      end_access = '0;
      wt_load    = 1'b0;
      wts        = '0;
      req_mode   = REQ_OFF;
      len_min    = 1;
      len_max    = 1;
      prev_gnt   = '0;
      prev_end   = '0;
      errors     = 0;
      mark       = 0;
      tests      = 0;
      for (int i = 0; i < N_REQ; i++)
         hold[i] = -1;
      model_reset();
      @(posedge clk);
      test_reset();
      test_round_robin();
      test_weighted();
      test_back_pressure();
      test_random();
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* wrr_arbiter.f */
+incdir+test
logic/wrr_pkg.sv
logic/arb_if.sv
logic/reset_sync.sv
logic/rr_picker.sv
logic/credit_counters.sv
logic/arb_fsm.sv
logic/wrr_arbiter.sv
test/tb_clock_gen.sv
test/tb_wrr_arbiter.sv

/* Bender.yml */
package:
  name: wrr_arbiter

sources:
  - files:
      - logic/wrr_pkg.sv
      - logic/arb_if.sv
      - logic/reset_sync.sv
      - logic/rr_picker.sv
      - logic/credit_counters.sv
      - logic/arb_fsm.sv
      - logic/wrr_arbiter.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_clock_gen.sv
      - test/tb_wrr_arbiter.sv
